// File: common/fetch_pkg.sv
// ----------------------------------------
// Types and constants for the fetch stage
// Strand fields are sized for up to four strands
// ----------------------------------------
`default_nettype none

package fetch_pkg;
	// Strand index width and the most strands a cache response can name
	localparam int STRAND_IDX_W = 2;
	localparam int MAX_STRANDS = 1 << STRAND_IDX_W;

	// Branch offset field sits in bits 24:5
	localparam int BRANCH_OFFSET_LSB = 5;
	localparam int BRANCH_OFFSET_W = 20;

	// Integer multiply in the format A and format B opcode fields
	localparam logic [5:0] OP_IMUL_A = 6'b000111;
	localparam logic [4:0] OP_IMUL_B = 5'b00111;

	// Top three instruction bits
	// Format B owns every code with bit 31 clear
	typedef enum logic [2:0] {
		FMT_B0 = 3'b000,
		FMT_B1 = 3'b001,
		FMT_B2 = 3'b010,
		FMT_B3 = 3'b011,
		FMT_C = 3'b100,
		FMT_D = 3'b101,
		FMT_A = 3'b110,
		FMT_E = 3'b111
	} fmt_e;

	// Branch type in bits 27:25, only meaningful when bits 31:28 are 1111
	typedef enum logic [2:0] {
		BR_ZERO = 3'b000,
		BR_NOT_ZERO = 3'b001,
		BR_ALL = 3'b010,
		BR_ALWAYS = 3'b011,
		BR_CALL = 3'b100,
		BR_NOT_ALL = 3'b101,
		BR_JUMP_REG = 3'b110,
		BR_CALL_REG = 3'b111
	} branch_op_e;

	// One queued instruction, pc holds the address after the instruction
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
		logic branch_predicted;
		logic long_latency;
	} fetch_entry_t;

	typedef struct packed {
		logic request;
		logic [31:0] addr;
		logic [STRAND_IDX_W-1:0] strand;
	} icache_req_t;

	// Data is in memory byte order
	typedef struct packed {
		logic hit;
		logic [31:0] data;
		logic [MAX_STRANDS-1:0] load_complete_strands;
		logic load_collision;
	} icache_resp_t;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
	} rollback_t;
endpackage

`default_nettype wire

// File: hw/strand_arbiter.sv
// ----------------------------------------
// Rotating priority arbiter
// Last granted strand drops to lowest priority
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module strand_arbiter #(
	parameter int NUM_STRANDS = 4
) (
	input wire clk,
	input wire reset,
	input wire [NUM_STRANDS-1:0] request_i,
	output logic [NUM_STRANDS-1:0] grant_oh_o
);
	localparam int IDX_W = (NUM_STRANDS > 1) ? $clog2(NUM_STRANDS) : 1;

	// Index of the most recently granted strand
	logic [IDX_W-1:0] last_idx_ff;
	logic [IDX_W-1:0] grant_idx;
	logic grant_valid;

	// Search starts just after the last grant and wraps around
	always_comb
	begin
		grant_oh_o = '0;
		grant_idx = last_idx_ff;
		grant_valid = 1'b0;
		for (int offset = 1; offset <= NUM_STRANDS; offset++)
		begin
			int cand;
			cand = (int'(last_idx_ff) + offset) % NUM_STRANDS;
			// First requester in priority order wins
			if (!grant_valid && request_i[cand])
			begin
				grant_valid = 1'b1;
				grant_idx = IDX_W'(cand);
				grant_oh_o[cand] = 1'b1;
			end
		end
	end

	// Order only moves when something is granted
	// Reset value gives strand 0 the first turn
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_idx_ff <= IDX_W'(NUM_STRANDS - 1);
		else if (grant_valid)
			last_idx_ff <= grant_idx;
	end
endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
// ----------------------------------------
// Fetch entry FIFO, registered output
// Flush beats a same-cycle enqueue
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 2
) (
	input wire clk,
	input wire reset,
	input wire flush_i,
	input wire enqueue_i,
	input wire fetch_pkg::fetch_entry_t value_i,
	input wire dequeue_i,
	output fetch_pkg::fetch_entry_t value_o,
	output logic empty_o,
	output logic full_o,
	output logic almost_full_o
);
	import fetch_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_entry_t storage [DEPTH];
	logic [PTR_W-1:0] rd_ptr_ff;
	logic [PTR_W-1:0] wr_ptr_ff;
	logic [CNT_W-1:0] count_ff;
	logic do_enqueue;
	logic do_dequeue;

	assign empty_o = count_ff == '0;
	assign full_o = count_ff == CNT_W'(DEPTH);
	// One slot left
	assign almost_full_o = count_ff == CNT_W'(DEPTH - 1);

	// Pop only when there is data, push when room exists after any pop
	assign do_dequeue = dequeue_i && !empty_o;
	assign do_enqueue = enqueue_i && (!full_o || do_dequeue);

	assign value_o = storage[rd_ptr_ff];

	// Payload storage, written at the tail
	always_ff @(posedge clk)
	begin
		if (do_enqueue && !flush_i)
			storage[wr_ptr_ff] <= value_i;
	end

	// Pointers and count
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr_ff <= '0;
			wr_ptr_ff <= '0;
			count_ff <= '0;
		end
		else if (flush_i)
		begin
			// Drop everything queued for this strand
			rd_ptr_ff <= '0;
			wr_ptr_ff <= '0;
			count_ff <= '0;
		end
		else
		begin
			if (do_enqueue)
				wr_ptr_ff <= (wr_ptr_ff == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_ff + 1'b1;

			if (do_dequeue)
				rd_ptr_ff <= (rd_ptr_ff == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_ff + 1'b1;

			// Count holds when push and pop coincide
			if (do_enqueue && !do_dequeue)
				count_ff <= count_ff + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count_ff <= count_ff - 1'b1;
		end
	end
endmodule

`default_nettype wire

// File: hw/instruction_predecode.sv
// ----------------------------------------
// Pure combinational predecode
// Static prediction, backward conditionals taken
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instruction_predecode (
	input wire [31:0] data_i,
	output logic [31:0] instruction_o,
	output logic branch_predicted_o,
	output logic [31:0] branch_offset_o,
	output logic long_latency_o
);
	import fetch_pkg::*;

	localparam int OFFSET_MSB = BRANCH_OFFSET_LSB + BRANCH_OFFSET_W - 1;

	fmt_e fmt;
	branch_op_e branch_op;
	logic is_branch;
	logic offset_negative;

	// Memory holds words in the opposite byte order
	assign instruction_o = {data_i[7:0], data_i[15:8], data_i[23:16], data_i[31:24]};

	assign fmt = fmt_e'(instruction_o[31:29]);
	assign branch_op = branch_op_e'(instruction_o[27:25]);

	// Branch class is 1111 in the top nibble
	assign is_branch = (fmt == FMT_E) && instruction_o[28];

	// Offset field sign-extended to a full address
	assign branch_offset_o = {
		{(32 - BRANCH_OFFSET_W){instruction_o[OFFSET_MSB]}},
		instruction_o[BRANCH_OFFSET_LSB +: BRANCH_OFFSET_W]
	};
	assign offset_negative = branch_offset_o[31];

	// Prediction
	always_comb
	begin
		branch_predicted_o = 1'b0;
		if (is_branch)
		begin
			case (branch_op)
				// Unconditional, always followed
				BR_ALWAYS, BR_CALL:
					branch_predicted_o = 1'b1;
				// Conditional, loops usually jump backward
				BR_ZERO, BR_NOT_ZERO, BR_ALL, BR_NOT_ALL:
					branch_predicted_o = offset_negative;
				// Register targets are unknown here
				default:
					branch_predicted_o = 1'b0;
			endcase
		end
	end

	// Long latency pipeline use
	always_comb
	begin
		case (fmt)
			// Bit 28 marks floating point ops
			FMT_A:
				long_latency_o = instruction_o[28] || (instruction_o[28:23] == OP_IMUL_A);
			FMT_B0, FMT_B1, FMT_B2, FMT_B3:
				long_latency_o = instruction_o[30:26] == OP_IMUL_B;
			default:
				long_latency_o = 1'b0;
		endcase
	end
endmodule

`default_nettype wire

// File: instruction_fetch/instruction_fetch_stage.sv
// ----------------------------------------
// Fetch stage, NUM_STRANDS up to four
// Cache answers exactly one cycle after request
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instruction_fetch_stage #(
	parameter int NUM_STRANDS = 4,
	parameter int FIFO_DEPTH = 2
) (
	input wire clk,
	input wire reset,

	// Instruction cache
	output fetch_pkg::icache_req_t icache_req_o,
	input wire fetch_pkg::icache_resp_t icache_resp_i,

	// Strand select stage
	output wire fetch_pkg::fetch_entry_t [NUM_STRANDS-1:0] if_entry_o,
	output logic [NUM_STRANDS-1:0] if_valid_o,
	input wire [NUM_STRANDS-1:0] ss_req_i,

	// Rollback from later stages
	input wire fetch_pkg::rollback_t [NUM_STRANDS-1:0] rollback_i
);
	import fetch_pkg::*;

	// Per-strand fetch address
	logic [31:0] pc_ff [NUM_STRANDS];
	logic [31:0] pc_nxt [NUM_STRANDS];

	// Strand whose response arrives this cycle
	logic [NUM_STRANDS-1:0] request_oh_ff;
	logic [NUM_STRANDS-1:0] grant_oh;

	// Strands parked on a cache miss
	logic [NUM_STRANDS-1:0] wait_ff;
	logic [NUM_STRANDS-1:0] wait_nxt;

	logic [NUM_STRANDS-1:0] load_complete;
	logic [NUM_STRANDS-1:0] enqueue;
	logic [NUM_STRANDS-1:0] eligible;
	logic [NUM_STRANDS-1:0] full;
	logic [NUM_STRANDS-1:0] almost_full;
	logic [NUM_STRANDS-1:0] empty;
	logic miss_wait;

	// Predecoded response word
	logic [31:0] instruction;
	logic branch_predicted;
	logic [31:0] branch_offset;
	logic long_latency;

	assign load_complete = icache_resp_i.load_complete_strands[NUM_STRANDS-1:0];

	// A plain miss parks the strand
	// A collision miss just retries
	assign miss_wait = !icache_resp_i.hit && (request_oh_ff != '0)
		&& !icache_resp_i.load_collision;

	// Completion frees a strand in the same cycle
	always_comb
	begin
		wait_nxt = wait_ff & ~load_complete;
		if (miss_wait)
			wait_nxt = wait_nxt | request_oh_ff;
	end

	// Hit data belongs to the strand granted last cycle
	assign enqueue = {NUM_STRANDS{icache_resp_i.hit}} & request_oh_ff;

	// Leave room for the entry landing this cycle
	// Anything granted now lands next cycle
	assign eligible = ~wait_nxt & ~full & ~(almost_full & enqueue);

	strand_arbiter #(
		.NUM_STRANDS(NUM_STRANDS)
	) u_strand_arbiter (
		.clk(clk),
		.reset(reset),
		.request_i(eligible),
		.grant_oh_o(grant_oh)
	);

	instruction_predecode u_instruction_predecode (
		.data_i(icache_resp_i.data),
		.instruction_o(instruction),
		.branch_predicted_o(branch_predicted),
		.branch_offset_o(branch_offset),
		.long_latency_o(long_latency)
	);

	// Next PC per strand
	// The PC still points at the word just returned on a hit
	always_comb
	begin
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (rollback_i[s].valid)
				pc_nxt[s] = rollback_i[s].pc;
			else if (!enqueue[s])
				pc_nxt[s] = pc_ff[s];
			else if (branch_predicted)
				pc_nxt[s] = pc_ff[s] + 32'd4 + branch_offset;
			else
				pc_nxt[s] = pc_ff[s] + 32'd4;
		end
	end

	// Request uses next-state PC so redirects and rollbacks apply at once
	// Quiet while reset is held
	always_comb
	begin
		icache_req_o.request = (grant_oh != '0) && !reset;
		icache_req_o.addr = pc_nxt[0];
		icache_req_o.strand = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (grant_oh[s])
			begin
				icache_req_o.addr = pc_nxt[s];
				icache_req_o.strand = STRAND_IDX_W'(s);
			end
		end
	end

	// Valid whenever the strand FIFO holds something
	assign if_valid_o = ~empty;

	for (genvar s = 0; s < NUM_STRANDS; s++)
	begin : g_strand
		fetch_entry_t entry;

		// Queued pc is the address after the fetched word
		assign entry.pc = pc_ff[s] + 32'd4;
		assign entry.instruction = instruction;
		assign entry.branch_predicted = branch_predicted;
		assign entry.long_latency = long_latency;

		// Rollback flushes and also discards a hit in the same cycle
		sync_fifo #(
			.DEPTH(FIFO_DEPTH)
		) u_sync_fifo (
			.clk(clk),
			.reset(reset),
			.flush_i(rollback_i[s].valid),
			.enqueue_i(enqueue[s]),
			.value_i(entry),
			.dequeue_i(ss_req_i[s] && if_valid_o[s]),
			.value_o(if_entry_o[s]),
			.empty_o(empty[s]),
			.full_o(full[s]),
			.almost_full_o(almost_full[s])
		);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				pc_ff[s] <= 32'h0;
			request_oh_ff <= '0;
			wait_ff <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				pc_ff[s] <= pc_nxt[s];
			request_oh_ff <= grant_oh;
			wait_ff <= wait_nxt;
		end
	end
endmodule

`default_nettype wire

// File: tb/fetch_model.svh
// ----------------------------------------
// Reference model for the fetch testbench
// Include inside a module after fetch_pkg import
// ----------------------------------------
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
// New bit enters at bit 0
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

function automatic logic [31:0] swap_bytes(input logic [31:0] word);
	return {word[7:0], word[15:8], word[23:16], word[31:24]};
endfunction

// Hash of the full address, every bit counts
function automatic logic [31:0] scramble(input logic [31:0] addr);
	logic [31:0] x;
	x = addr ^ (addr >> 15);
	x = x * 32'h2c1b3c6d;
	x = x ^ (x >> 12);
	x = x * 32'h297a2d39;
	return x ^ (x >> 15);
endfunction

// Program image in execution byte order
function automatic logic [31:0] build_instruction(input logic [31:0] addr);
	logic [31:0] h;
	logic [19:0] off;
	h = scramble(addr);
	// Branch target 1 to 16 words away, backward when bit 12 is set
	off = 20'((32'(h[11:8]) + 32'd1) << 2);
	if (h[12])
		off = -off;
	case (h[3:0])
		4'd6: return {1'b0, OP_IMUL_B, h[31:6]};
		4'd7: return {3'b110, OP_IMUL_A, h[31:9]};
		// Format A with random bit 28, floating point half the time
		4'd8: return {3'b110, h[31:3]};
		4'd9: return {2'b10, h[31:2]};
		// Branch class, every branch type
		4'd10, 4'd11, 4'd12, 4'd13, 4'd14, 4'd15:
			return {4'b1111, h[15:13], off, h[20:16]};
		default: return {1'b0, h[31:1]};
	endcase
endfunction

// Word as the cache returns it
function automatic logic [31:0] memory_word(input logic [31:0] addr);
	return swap_bytes(build_instruction(addr));
endfunction

// Unconditional always, conditional only when jumping backward
function automatic logic predicts_taken(input logic [31:0] instr);
	if (instr[31:28] != 4'b1111)
		return 1'b0;
	case (branch_op_e'(instr[27:25]))
		BR_ALWAYS, BR_CALL: return 1'b1;
		BR_ZERO, BR_NOT_ZERO, BR_ALL, BR_NOT_ALL: return instr[24];
		default: return 1'b0;
	endcase
endfunction

function automatic logic [31:0] target_offset(input logic [31:0] instr);
	return {{12{instr[24]}}, instr[24:5]};
endfunction

function automatic logic is_long_latency(input logic [31:0] instr);
	if (instr[31:29] == FMT_A)
		return instr[28] || (instr[28:23] == OP_IMUL_A);
	if (!instr[31])
		return instr[30:26] == OP_IMUL_B;
	return 1'b0;
endfunction

function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc, input logic [31:0] instr);
	if (predicts_taken(instr))
		return pc + 32'd4 + target_offset(instr);
	return pc + 32'd4;
endfunction

// Entry the strand select stage should see for a fetch at pc
function automatic fetch_entry_t expected_entry(input logic [31:0] pc);
	fetch_entry_t e;
	e.instruction = build_instruction(pc);
	e.pc = pc + 32'd4;
	e.branch_predicted = predicts_taken(e.instruction);
	e.long_latency = is_long_latency(e.instruction);
	return e;
endfunction

`endif

// File: tb/tb_fetch.sv
// ----------------------------------------
// Fetch stage testbench, four strands, depth 2
// Cache model answers every request one cycle later
// ----------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;
	import fetch_pkg::*;

	`include "fetch_model.svh"

	localparam int NUM_STRANDS = 4;
	localparam int FIFO_DEPTH = 2;
	localparam int RANDOM_CYCLES = 3000;
	localparam int PROGRESS_TIMEOUT = 300;

	logic clk;
	logic reset;
	icache_req_t icache_req;
	icache_resp_t icache_resp;
	fetch_entry_t [NUM_STRANDS-1:0] if_entry;
	logic [NUM_STRANDS-1:0] if_valid;
	logic [NUM_STRANDS-1:0] ss_req;
	rollback_t [NUM_STRANDS-1:0] rollback;

	logic [15:0] lfsr_state = 16'd88;
	// Request seen last cycle, answered this cycle
	icache_req_t last_req;
	// Fetch side and pop side address per strand
	logic [31:0] fetch_pc [NUM_STRANDS];
	logic [31:0] pop_pc [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] wait_model;
	logic [NUM_STRANDS-1:0] seen_valid;
	int miss_timer [NUM_STRANDS];
	bit rollback_seen [NUM_STRANDS];
	int delivered [NUM_STRANDS];
	int progress_base [NUM_STRANDS];
	int rollback_cnt;
	int check_cnt [1:6];
	int fail_cnt [1:6];
	string test_name [1:6] = '{"reset state", "in-order delivery", "branch prediction",
		"long-latency flag", "rollback", "arbitration and progress"};

	instruction_fetch_stage #(
		.NUM_STRANDS(NUM_STRANDS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_instruction_fetch_stage (
		.clk(clk),
		.reset(reset),
		.icache_req_o(icache_req),
		.icache_resp_i(icache_resp),
		.if_entry_o(if_entry),
		.if_valid_o(if_valid),
		.ss_req_i(ss_req),
		.rollback_i(rollback)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// Hard limit on simulated time
	initial
	begin
		#100000;
		$display("Simulation stopped by the watchdog before the test sequence ended");
		$display("RESULT: FAIL");
		$finish;
	end

	// One LFSR step per bit, first bit lands highest
	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
		return v;
	endfunction

	task automatic check_that(input int test_id, input bit ok, input string msg);
		check_cnt[test_id]++;
		assert (ok)
		else
		begin
			fail_cnt[test_id]++;
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
		end
	endtask

	function automatic bit progress_done();
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (delivered[s] < progress_base[s] + 4)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	task automatic report_test(input int id);
		$display("Test %0d %s: %0d checks, %0d failed", id, test_name[id],
			check_cnt[id], fail_cnt[id]);
	endtask

	// One clock cycle, entered 1 ns after a rising edge
	task automatic run_cycle(input bit allow_rollback, input bit pop_all);
		icache_resp_t resp;
		rollback_t [NUM_STRANDS-1:0] rb;
		logic [NUM_STRANDS-1:0] pops;
		logic [NUM_STRANDS-1:0] hit_oh;
		logic [NUM_STRANDS-1:0] miss_oh;
		logic [NUM_STRANDS-1:0] wait_now;
		logic [31:0] nxt [NUM_STRANDS];
		fetch_entry_t want;
		icache_req_t req;
		int rb_strand;

		resp = '0;
		hit_oh = '0;
		miss_oh = '0;
		// Completion pulse once a miss delay runs out
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (miss_timer[s] > 0)
			begin
				miss_timer[s]--;
				if (miss_timer[s] == 0)
					resp.load_complete_strands[s] = 1'b1;
			end
		end
		// Three hits in four, the rest split between collision and miss
		if (last_req.request)
		begin
			resp.data = memory_word(last_req.addr);
			if (take_bits(2) != 0)
			begin
				resp.hit = 1'b1;
				hit_oh[last_req.strand] = 1'b1;
			end
			else if (take_bits(1) != 0)
				resp.load_collision = 1'b1;
			else
			begin
				miss_oh[last_req.strand] = 1'b1;
				miss_timer[last_req.strand] = 1 + take_bits(2);
			end
		end
		for (int s = 0; s < NUM_STRANDS; s++)
			pops[s] = pop_all ? 1'b1 : take_bits(1) != 0;
		rb = '0;
		// Rare rollback, never with a pop of the same strand
		if (allow_rollback && take_bits(5) == 0)
		begin
			rb_strand = take_bits(2) % NUM_STRANDS;
			rb[rb_strand].valid = 1'b1;
			rb[rb_strand].pc = (32'(take_bits(10)) + 32'd1) << 2;
			pops[rb_strand] = 1'b0;
		end
		icache_resp = resp;
		rollback = rb;
		ss_req = pops;

		@(negedge clk);
		req = icache_req;
		seen_valid = if_valid;
		// Popped entries against the stream model
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (pops[s] && if_valid[s])
			begin
				want = expected_entry(pop_pc[s]);
				check_that(2, if_entry[s].pc == want.pc, $sformatf(
					"strand %0d pc %h, expected %h", s, if_entry[s].pc, want.pc));
				check_that(2, if_entry[s].instruction == want.instruction, $sformatf(
					"strand %0d instruction %h, expected %h", s,
					if_entry[s].instruction, want.instruction));
				check_that(3, if_entry[s].branch_predicted == want.branch_predicted,
					$sformatf("strand %0d branch_predicted wrong at pc %h", s, want.pc));
				check_that(4, if_entry[s].long_latency == want.long_latency,
					$sformatf("strand %0d long_latency wrong for %h", s, want.instruction));
				// First entry after a rollback comes from the new pc
				if (rollback_seen[s])
					check_that(5, if_entry[s].pc == want.pc, $sformatf(
						"strand %0d stale entry %h after rollback", s, if_entry[s].pc));
				rollback_seen[s] = 1'b0;
				pop_pc[s] = next_fetch_pc(pop_pc[s], want.instruction);
				delivered[s]++;
			end
		end
		// Miss-wait and fetch address model
		wait_now = (wait_model & ~resp.load_complete_strands[NUM_STRANDS-1:0]) | miss_oh;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (rb[s].valid)
			begin
				nxt[s] = rb[s].pc;
				pop_pc[s] = rb[s].pc;
				rollback_seen[s] = 1'b1;
				rollback_cnt++;
			end
			else if (hit_oh[s])
				nxt[s] = next_fetch_pc(fetch_pc[s], swap_bytes(resp.data));
			else
				nxt[s] = fetch_pc[s];
		end
		if (req.request)
		begin
			check_that(6, !wait_now[req.strand], $sformatf(
				"request for strand %0d while waiting on a miss", req.strand));
			check_that(3, req.addr == nxt[req.strand], $sformatf(
				"strand %0d request addr %h, expected %h", req.strand, req.addr,
				nxt[req.strand]));
		end
		for (int s = 0; s < NUM_STRANDS; s++)
			fetch_pc[s] = nxt[s];
		wait_model = wait_now;
		last_req = req;
		@(posedge clk);
		#1;
	endtask

	initial
	begin
		int waited;
		int total_checks;
		int total_fails;

		reset = 1'b1;
		icache_resp = '0;
		ss_req = '0;
		rollback = '0;
		last_req = '0;
		wait_model = '0;
		seen_valid = '0;
		rollback_cnt = 0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			fetch_pc[s] = 32'h0;
			pop_pc[s] = 32'h0;
			miss_timer[s] = 0;
			rollback_seen[s] = 1'b0;
			delivered[s] = 0;
			progress_base[s] = 0;
		end
		for (int t = 1; t <= 6; t++)
		begin
			check_cnt[t] = 0;
			fail_cnt[t] = 0;
		end

		// Outputs stay quiet while reset is held
		repeat (3)
		begin
			@(posedge clk);
			@(negedge clk);
			check_that(1, if_valid == '0 && !icache_req.request, "output active during reset");
		end
		@(posedge clk);
		#1;
		reset = 1'b0;

		// First cycle out of reset, every strand eligible
		run_cycle(1'b0, 1'b0);
		check_that(1, seen_valid == '0, $sformatf("if_valid %b after reset", seen_valid));
		check_that(1, last_req.request && last_req.addr == 32'h0, $sformatf(
			"first request %b at addr %h", last_req.request, last_req.addr));
		report_test(1);

		repeat (RANDOM_CYCLES)
			run_cycle(1'b1, 1'b0);
		check_that(5, rollback_cnt > 0, "no rollback was generated");

		// All strands pop every cycle and must keep delivering
		for (int s = 0; s < NUM_STRANDS; s++)
			progress_base[s] = delivered[s];
		waited = 0;
		while (!progress_done() && waited < PROGRESS_TIMEOUT)
		begin
			run_cycle(1'b0, 1'b1);
			waited++;
		end
		check_cnt[6]++;
		assert (progress_done())
		else
		begin
			fail_cnt[6]++;
			$display("Timed out at %0t ns waiting for every strand to deliver entries", $time);
		end

		for (int t = 2; t <= 6; t++)
			report_test(t);
		total_checks = 0;
		total_fails = 0;
		for (int t = 1; t <= 6; t++)
		begin
			total_checks += check_cnt[t];
			total_fails += fail_cnt[t];
		end
		$display("Total: %0d checks, %0d failed", total_checks, total_fails);
		if (total_fails == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
common/fetch_pkg.sv
hw/strand_arbiter.sv
hw/sync_fifo.sv
hw/instruction_predecode.sv
instruction_fetch/instruction_fetch_stage.sv
tb/tb_fetch.sv
